/* Makefile */
TOOL       ?= verilator
TOP        := tb_stage_control
FILELIST   := stage_control.f
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/game_pkg.sv */
package game_pkg;

    typedef logic [9:0] coord_t;      // screen coordinate
    typedef logic [3:0] stage_t;
    typedef logic [3:0] collision_t;  // one bit per blocked direction

    typedef enum logic [1:0] {
        DIR_POS_H = 2'd0,
        DIR_NEG_H = 2'd1,
        DIR_POS_V = 2'd2,
        DIR_NEG_V = 2'd3
    } dir_t;

    // bit positions inside collision_t
    localparam int BLOCK_NEG_H = 0;
    localparam int BLOCK_POS_H = 1;
    localparam int BLOCK_POS_V = 2;
    localparam int BLOCK_NEG_V = 3;

    localparam int TILE_SIZE = 20;    // wall tile pitch
    localparam int N_WALLS   = 40;

    // wall tile corners, index matches tile number
    localparam coord_t WALL_H [0:N_WALLS-1] = '{
        320, 300, 280, 260, 240, 220, 200, 180,
        160, 140, 120, 100,  80,  60,  40,  20,
        320, 300, 280, 260, 240, 220, 200, 180,
        160, 140, 120, 100,  80,  60,  40,  20,
        280, 100, 320, 300,  80,  60,  40,  20
    };

    localparam coord_t WALL_V [0:N_WALLS-1] = '{
        120, 120, 120, 160, 180, 160, 180, 180,
        180, 180, 180, 140, 140, 140, 140, 140,
         60,  60,  60,  60,  60,  60,  60,  60,
         60,  60,  60,  60,  60,  60,  60,  60,
        140, 160, 140, 140, 160, 160, 160, 160
    };

    // player leaves the screen past these
    localparam coord_t EDGE_LOW  = 10'd20;
    localparam coord_t EDGE_HIGH = 10'd319;

    localparam coord_t SPAWN0_H = 10'd150;  // first stage only
    localparam coord_t SPAWN0_V = 10'd110;
    localparam coord_t SPAWN_H  = 10'd25;
    localparam coord_t SPAWN_V  = 10'd25;

    localparam coord_t MONSTER_H0 = 10'd160;
    localparam coord_t MONSTER_V0 = 10'd120;

    // monster wander box
    localparam coord_t MONSTER_H_MIN = 10'd20;
    localparam coord_t MONSTER_H_MAX = 10'd300;
    localparam coord_t MONSTER_V_MIN = 10'd20;
    localparam coord_t MONSTER_V_MAX = 10'd220;

    localparam logic [12:0] LFSR_SEED = 13'h000F;  // any nonzero value works

endpackage

/* design/lfsr13.sv */
module lfsr13 (
    input  logic        clk,
    input  logic        rst,
    input  logic        stage_change,
    output logic [12:0] rnd
);
    import game_pkg::*;

    logic [12:0] state;
    logic [3:0]  shift_cnt;
    logic        feedback;

    assign feedback = state[12] ^ state[3] ^ state[2] ^ state[0];

    always_ff @(posedge clk) begin
        if (rst || stage_change) begin
            state     <= LFSR_SEED;
            shift_cnt <= '0;
            rnd       <= LFSR_SEED;
        end else begin
            state <= {state[11:0], feedback};
            if (shift_cnt == 4'd12) begin
                shift_cnt <= '0;
                rnd       <= state;   // fresh word every 13 shifts
            end else begin
                shift_cnt <= shift_cnt + 1'b1;
            end
        end
    end

    // all-zero state would lock up
    a_nonzero: assert property (@(posedge clk) disable iff (rst)
        state != '0);

endmodule

/* design/monster_walker.sv */
module monster_walker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stage_change,
    input  logic                 tick,
    input  game_pkg::collision_t blocked,
    input  logic [12:0]          rnd,
    output game_pkg::coord_t     pos_h,
    output game_pkg::coord_t     pos_v
);
    import game_pkg::*;

    dir_t       heading;
    logic       stuck;
    logic [1:0] pick;
    logic [1:0] turn_to;
    coord_t     next_h;
    coord_t     next_v;

    // blocked by a wall or by the wander box
    always_comb begin
        case (heading)
            DIR_POS_H: stuck = blocked[BLOCK_POS_H] || (pos_h >= MONSTER_H_MAX);
            DIR_NEG_H: stuck = blocked[BLOCK_NEG_H] || (pos_h <= MONSTER_H_MIN);
            DIR_POS_V: stuck = blocked[BLOCK_POS_V] || (pos_v >= MONSTER_V_MAX);
            default:   stuck = blocked[BLOCK_NEG_V] || (pos_v <= MONSTER_V_MIN);
        endcase
    end

    // choose among the other three headings
    assign pick    = 2'(rnd % 13'd3);
    assign turn_to = (pick >= heading) ? pick + 1'b1 : pick;

    always_comb begin
        next_h = pos_h;
        next_v = pos_v;
        if (!stuck) begin
            case (heading)
                DIR_POS_H: next_h = pos_h + 1'b1;
                DIR_NEG_H: next_h = pos_h - 1'b1;
                DIR_POS_V: next_v = pos_v + 1'b1;
                default:   next_v = pos_v - 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || stage_change) begin
            pos_h   <= MONSTER_H0;
            pos_v   <= MONSTER_V0;
            heading <= DIR_POS_H;
        end else if (tick) begin
            pos_h <= next_h;      // holds when stuck
            pos_v <= next_v;
            if (stuck) begin
                heading <= dir_t'(turn_to);
            end
        end
    end

    a_in_box: assert property (@(posedge clk) disable iff (rst)
        pos_h >= MONSTER_H_MIN && pos_h <= MONSTER_H_MAX
        && pos_v >= MONSTER_V_MIN && pos_v <= MONSTER_V_MAX);

endmodule

/* design/player_mover.sv */
module player_mover (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stage_change,
    input  game_pkg::stage_t     stage,
    input  logic                 tick,
    input  logic                 key_w,
    input  logic                 key_a,
    input  logic                 key_s,
    input  logic                 key_d,
    input  game_pkg::collision_t blocked,
    output game_pkg::coord_t     pos_h,
    output game_pkg::coord_t     pos_v
);
    import game_pkg::*;

    coord_t next_h;
    coord_t next_v;
    coord_t spawn_h;
    coord_t spawn_v;

    // stage has already advanced when stage_change is seen here
    assign spawn_h = (stage == '0) ? SPAWN0_H : SPAWN_H;
    assign spawn_v = (stage == '0) ? SPAWN0_V : SPAWN_V;

    // W > S > A > D, only one key acts
    always_comb begin
        next_h = pos_h;
        next_v = pos_v;
        if (key_w) begin
            if (!blocked[BLOCK_POS_V]) begin
                next_v = pos_v + 1'b1;
            end
        end else if (key_s) begin
            if (!blocked[BLOCK_NEG_V]) begin
                next_v = pos_v - 1'b1;
            end
        end else if (key_a) begin
            if (!blocked[BLOCK_POS_H]) begin
                next_h = pos_h + 1'b1;
            end
        end else if (key_d) begin
            if (!blocked[BLOCK_NEG_H]) begin
                next_h = pos_h - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pos_h <= SPAWN0_H;
            pos_v <= SPAWN0_V;
        end else if (stage_change) begin
            pos_h <= spawn_h;   // respawn on new stage
            pos_v <= spawn_v;
        end else if (tick) begin
            pos_h <= next_h;
            pos_v <= next_v;
        end
    end

    // no drift between frames
    a_hold: assert property (@(posedge clk) disable iff (rst)
        !tick && !stage_change |=> $stable(pos_h) && $stable(pos_v));

    // a frame moves at most one pixel along one axis
    a_step: assert property (@(posedge clk) disable iff (rst)
        tick && !stage_change |=> ($stable(pos_v) && ($stable(pos_h)
                                     || pos_h == $past(pos_h) + 1'b1
                                     || pos_h == $past(pos_h) - 1'b1))
              || ($stable(pos_h) && (pos_v == $past(pos_v) + 1'b1
                                     || pos_v == $past(pos_v) - 1'b1)));

endmodule

/* design/stage_control.sv */
module stage_control #(
    parameter int MAX_STAGE = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  logic             key_w,
    input  logic             key_a,
    input  logic             key_s,
    input  logic             key_d,
    output game_pkg::stage_t stage,
    output logic             stage_change,
    output game_pkg::coord_t player_h,
    output game_pkg::coord_t player_v,
    output game_pkg::coord_t monster_h,
    output game_pkg::coord_t monster_v
);
    import game_pkg::*;

    collision_t  player_blocked;
    collision_t  monster_blocked;
    logic [12:0] rnd;

    stage_sequencer #(
        .MAX_STAGE(MAX_STAGE)
    ) stage_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .player_h    (player_h),
        .stage       (stage),
        .stage_change(stage_change)
    );

    player_mover player_mover_i (
        .clk         (clk),
        .rst         (rst),
        .stage_change(stage_change),
        .stage       (stage),
        .tick        (tick),
        .key_w       (key_w),
        .key_a       (key_a),
        .key_s       (key_s),
        .key_d       (key_d),
        .blocked     (player_blocked),
        .pos_h       (player_h),
        .pos_v       (player_v)
    );

    wall_map player_walls_i (
        .pos_h  (player_h),
        .pos_v  (player_v),
        .blocked(player_blocked)
    );

    lfsr13 lfsr13_i (
        .clk         (clk),
        .rst         (rst),
        .stage_change(stage_change),
        .rnd         (rnd)
    );

    monster_walker monster_walker_i (
        .clk         (clk),
        .rst         (rst),
        .stage_change(stage_change),
        .tick        (tick),
        .blocked     (monster_blocked),
        .rnd         (rnd),
        .pos_h       (monster_h),
        .pos_v       (monster_v)
    );

    wall_map monster_walls_i (
        .pos_h  (monster_h),
        .pos_v  (monster_v),
        .blocked(monster_blocked)
    );

endmodule

/* design/stage_sequencer.sv */
module stage_sequencer #(
    parameter int MAX_STAGE = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  game_pkg::coord_t player_h,
    output game_pkg::stage_t stage,
    output logic             stage_change
);
    import game_pkg::*;

    logic at_low;
    logic at_high;

    assign at_low  = (player_h <= EDGE_LOW);
    assign at_high = (player_h >= EDGE_HIGH);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage        <= '0;
            stage_change <= 1'b0;
        end else begin
            stage_change <= 1'b0;
            if (!stage_change) begin   // player still at the edge during respawn
                if (at_low) begin
                    stage_change <= 1'b1;
                    if (stage < MAX_STAGE) begin
                        stage <= stage + 1'b1;
                    end
                end else if (at_high) begin
                    stage_change <= 1'b1;
                    if (stage != '0) begin
                        stage <= stage - 1'b1;
                    end
                end
            end
        end
    end

    a_stage_max: assert property (@(posedge clk) disable iff (rst)
        stage <= MAX_STAGE);

    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        stage_change |=> !stage_change);

endmodule

/* design/wall_map.sv */
module wall_map (
    input  game_pkg::coord_t     pos_h,
    input  game_pkg::coord_t     pos_v,
    output game_pkg::collision_t blocked
);
    import game_pkg::*;

    localparam logic [10:0] TS = 11'(TILE_SIZE);

    // one extra bit so the +TS sums never wrap
    logic [10:0] ph;
    logic [10:0] pv;
    collision_t  hit [N_WALLS];

    assign ph = {1'b0, pos_h};
    assign pv = {1'b0, pos_v};

    for (genvar i = 0; i < N_WALLS; i++) begin : g_wall
        localparam logic [10:0] WH = {1'b0, WALL_H[i]};
        localparam logic [10:0] WV = {1'b0, WALL_V[i]};

        logic       row_overlap;
        logic       col_overlap;
        collision_t hit_w;

        // strict overlap test written without subtraction
        assign row_overlap = (pv + TS > WV) && (pv < WV + TS);
        assign col_overlap = (ph + TS > WH) && (ph < WH + TS);

        always_comb begin
            hit_w = '0;
            if (row_overlap) begin
                hit_w[BLOCK_NEG_H] = (ph == WH + TS);  // wall on the low-h side
                hit_w[BLOCK_POS_H] = (ph + TS == WH);  // wall on the high-h side
            end else if (col_overlap) begin
                hit_w[BLOCK_POS_V] = (pv + TS == WV);
                hit_w[BLOCK_NEG_V] = (pv == WV + TS);
            end
        end

        assign hit[i] = hit_w;
    end

    always_comb begin
        blocked = '0;
        for (int i = 0; i < N_WALLS; i++) begin
            blocked = blocked | hit[i];
        end
    end

endmodule

/* stage_control.f */
design/game_pkg.sv
design/wall_map.sv
design/player_mover.sv
design/stage_sequencer.sv
design/lfsr13.sv
design/monster_walker.sv
design/stage_control.sv
verif/tb_stage_control.sv

/* verif/tb_stage_control.sv */
module tb_stage_control;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_STAGE = 10;
    localparam logic [3:0] K_W = 4'b1000;  // key word is {w, a, s, d}
    localparam logic [3:0] K_A = 4'b0100;
    localparam logic [3:0] K_S = 4'b0010;
    localparam logic [3:0] K_D = 4'b0001;

    typedef struct {
        string      name;
        logic [3:0] keys;
        int         ticks;        // tick budget, also the timeout of a stage wait
        int         gap;          // idle cycles after each tick
        bit         wait_change;
        int         exp_stage;
        int         exp_h;
        int         exp_v;
    } row_t;

    logic       clk;
    logic       rst;
    logic       tick;
    logic       key_w;
    logic       key_a;
    logic       key_s;
    logic       key_d;
    logic [3:0] stage;
    logic       stage_change;
    logic [9:0] player_h;
    logic [9:0] player_v;
    logic [9:0] monster_h;
    logic [9:0] monster_v;

    // reference copy of wall tiles 0 to 39
    int wall_h_ref [40] = '{
        320, 300, 280, 260, 240, 220, 200, 180, 160, 140, 120, 100,  80,  60,  40,  20,
        320, 300, 280, 260, 240, 220, 200, 180, 160, 140, 120, 100,  80,  60,  40,  20,
        280, 100, 320, 300,  80,  60,  40,  20
    };
    int wall_v_ref [40] = '{
        120, 120, 120, 160, 180, 160, 180, 180, 180, 180, 180, 140, 140, 140, 140, 140,
         60,  60,  60,  60,  60,  60,  60,  60,  60,  60,  60,  60,  60,  60,  60,  60,
        140, 160, 140, 140, 160, 160, 160, 160
    };

    row_t       rows [$];
    string      cur_test = "startup";
    int         err_count = 0;
    int         check_count = 0;
    int         row_pulses = 0;
    int         seed;
    int         m_stage;
    bit         m_sc;
    logic [9:0] m_h;
    logic [9:0] m_v;
    bit         m_ready = 1'b0;
    bit         last_resp;
    bit         last_tick;
    logic [9:0] mon_h_prev;
    logic [9:0] mon_v_prev;

    stage_control #(
        .MAX_STAGE(MAX_STAGE)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .key_w       (key_w),
        .key_a       (key_a),
        .key_s       (key_s),
        .key_d       (key_d),
        .stage       (stage),
        .stage_change(stage_change),
        .player_h    (player_h),
        .player_v    (player_v),
        .monster_h   (monster_h),
        .monster_v   (monster_v)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bits: 0 wall at low h, 1 wall at high h, 2 wall at high v, 3 wall at low v
    function automatic logic [3:0] wall_hits(int ph, int pv);
        logic [3:0] b;
        b = '0;
        for (int i = 0; i < 40; i++) begin
            if (pv > wall_v_ref[i] - 20 && pv < wall_v_ref[i] + 20) begin
                b[0] = b[0] | (ph == wall_h_ref[i] + 20);
                b[1] = b[1] | (ph + 20 == wall_h_ref[i]);
            end else if (ph > wall_h_ref[i] - 20 && ph < wall_h_ref[i] + 20) begin
                b[2] = b[2] | (pv + 20 == wall_v_ref[i]);
                b[3] = b[3] | (pv == wall_v_ref[i] + 20);
            end
        end
        return b;
    endfunction

    // player and stage model, one step per clock
    always @(posedge clk) begin : ref_model
        logic [3:0] b;
        int         nh;
        int         nv;
        if (rst) begin
            m_stage   = 0;
            m_sc      = 1'b0;
            m_h       = 10'd150;
            m_v       = 10'd110;
            m_ready   = 1'b1;
            last_resp = 1'b1;
            last_tick = 1'b0;
        end else begin
            last_resp = m_sc;
            last_tick = tick;
            nh = int'(m_h);
            nv = int'(m_v);
            b = wall_hits(nh, nv);
            if (m_sc) begin
                nh = (m_stage == 0) ? 150 : 25;   // stage is already the new one
                nv = (m_stage == 0) ? 110 : 25;
            end else if (tick) begin
                if (key_w) begin
                    nv = b[2] ? nv : nv + 1;
                end else if (key_s) begin
                    nv = b[3] ? nv : nv - 1;
                end else if (key_a) begin
                    nh = b[1] ? nh : nh + 1;
                end else if (key_d) begin
                    nh = b[0] ? nh : nh - 1;
                end
            end
            if (m_sc) begin
                m_sc = 1'b0;
            end else if (m_h <= 10'd20) begin
                m_sc = 1'b1;
                m_stage = (m_stage < MAX_STAGE) ? m_stage + 1 : m_stage;
            end else if (m_h >= 10'd319) begin
                m_sc = 1'b1;
                m_stage = (m_stage > 0) ? m_stage - 1 : m_stage;
            end
            m_h = 10'(nh);
            m_v = 10'(nv);
        end
    end

    task automatic compare_val(input string what, input int exp, input int act);
        check_count++;
        assert (act == exp) else begin
            $display("FAILED %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    always @(negedge clk) begin : output_check
        int dh;
        int dv;
        if (m_ready) begin
            compare_val("stage", m_stage, int'(stage));
            compare_val("stage_change", int'(m_sc), int'(stage_change));
            compare_val("player_h", int'(m_h), int'(player_h));
            compare_val("player_v", int'(m_v), int'(player_v));
            check_count++;
            assert (monster_h >= 10'd20 && monster_h <= 10'd300
                    && monster_v >= 10'd20 && monster_v <= 10'd220) else begin
                $display("monster left its box at (%0d, %0d) in %s",
                         monster_h, monster_v, cur_test);
                err_count++;
            end
            if (last_resp) begin
                compare_val("monster_h after respawn", 160, int'(monster_h));
                compare_val("monster_v after respawn", 120, int'(monster_v));
            end else begin
                dh = int'(monster_h) - int'(mon_h_prev);
                dv = int'(monster_v) - int'(mon_v_prev);
                dh = (dh < 0) ? -dh : dh;
                dv = (dv < 0) ? -dv : dv;
                check_count++;
                assert (dh + dv <= (last_tick ? 1 : 0)) else begin
                    $display("monster jumped by %0d/%0d in one cycle in %s (tick was %0b)",
                             dh, dv, cur_test, last_tick);
                    err_count++;
                end
            end
        end
        mon_h_prev = monster_h;
        mon_v_prev = monster_v;
    end

    task automatic next_cycle();
        @(negedge clk);
        if (stage_change) begin
            row_pulses++;
        end
    endtask

    task automatic drive_keys(input logic [3:0] keys);
        {key_w, key_a, key_s, key_d} = keys;
    endtask

    task automatic apply_tick(input int gap);
        tick = 1'b1;
        next_cycle();
        tick = 1'b0;
        repeat (gap) next_cycle();
    endtask

    function automatic void add_row(string name, logic [3:0] keys, int ticks, int gap,
                                    bit wait_change, int exp_stage, int exp_h, int exp_v);
        row_t r;
        r.name        = name;
        r.keys        = keys;
        r.ticks       = ticks;
        r.gap         = gap;
        r.wait_change = wait_change;
        r.exp_stage   = exp_stage;
        r.exp_h       = exp_h;
        r.exp_v       = exp_v;
        rows.push_back(r);
    endfunction

    task automatic build_table();
        add_row("tick_no_key",      4'b0000,         4,   0, 0, 0, 150, 110);
        add_row("w_step",           K_W,             5,   2, 0, 0, 150, 115);
        add_row("w_beats_a",        K_W | K_A,       3,   1, 0, 0, 150, 118);
        add_row("w_beats_s",        K_W | K_S,       1,   0, 0, 0, 150, 119);
        add_row("s_beats_a_d",      K_S | K_A | K_D, 4,   0, 0, 0, 150, 115);
        add_row("a_step",           K_A,             3,   3, 0, 0, 153, 115);
        add_row("d_step",           K_D,             3,   0, 0, 0, 150, 115);
        add_row("w_into_wall",      K_W,             60,  0, 0, 0, 150, 160);
        add_row("s_to_lower_wall",  K_S,             90,  0, 0, 0, 150, 80);
        add_row("a_exit_at_stage0", K_A,             200, 0, 1, 0, 150, 110);
        add_row("d_advance_1",      K_D,             200, 0, 1, 1, 25, 25);
        for (int k = 2; k <= MAX_STAGE; k++) begin
            add_row($sformatf("d_advance_%0d", k), K_D, 20, 0, 1, k, 25, 25);
        end
        add_row("d_saturate",       K_D,             20,  0, 1, MAX_STAGE, 25, 25);
        add_row("a_back",           K_A,             400, 0, 1, MAX_STAGE - 1, 25, 25);
        add_row("a_back_again",     K_A,             400, 0, 1, MAX_STAGE - 2, 25, 25);
    endtask

    task automatic run_row(input row_t r);
        int n;
        cur_test = r.name;
        row_pulses = 0;
        n = 0;
        drive_keys(r.keys);
        while (n < r.ticks && !(r.wait_change && row_pulses != 0)) begin
            apply_tick(r.gap);
            n++;
        end
        if (r.wait_change) begin
            check_count++;
            assert (row_pulses != 0) else begin
                $display("no stage change within %0d ticks in %s", r.ticks, r.name);
                err_count++;
            end
        end
        drive_keys(4'b0000);
        next_cycle();
        if (r.wait_change) begin
            compare_val("player_h at respawn", r.exp_h, int'(player_h));
            compare_val("player_v at respawn", r.exp_v, int'(player_v));
        end
        repeat (3) next_cycle();
        compare_val("stage_change pulses", r.wait_change ? 1 : 0, row_pulses);
        compare_val("final stage", r.exp_stage, int'(stage));
        compare_val("final player_h", r.exp_h, int'(player_h));
        compare_val("final player_v", r.exp_v, int'(player_v));
    endtask

    task automatic random_mix();
        logic [3:0] keys;
        int         n_ticks;
        int         gap;
        cur_test = "random_mix";
        for (int i = 0; i < 80; i++) begin
            keys = 4'($random(seed));
            n_ticks = 1 + int'($unsigned($random(seed)) % 32'd8);
            gap = int'($unsigned($random(seed)) % 32'd3);
            drive_keys(keys);
            repeat (n_ticks) apply_tick(gap);
        end
        drive_keys(4'b0000);
        repeat (4) next_cycle();
    endtask

    initial begin
        rst = 1'b1;
        tick = 1'b0;
        key_w = 1'b0;
        key_a = 1'b0;
        key_s = 1'b0;
        key_d = 1'b0;
        seed = 32'h9c85a03b;
        build_table();
        repeat (4) next_cycle();
        rst = 1'b0;
        cur_test = "reset";
        next_cycle();
        compare_val("stage", 0, int'(stage));
        compare_val("stage_change", 0, int'(stage_change));
        compare_val("player_h", 150, int'(player_h));
        compare_val("player_v", 110, int'(player_v));
        compare_val("monster_h", 160, int'(monster_h));
        compare_val("monster_v", 120, int'(monster_v));
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        random_mix();
        $display("checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
